// File: source/tcp_hdr_pkg.sv
`default_nettype none

package tcp_hdr_pkg;

  // Header sizes in bytes
  localparam int MIN_HDR_LEN   = 20;
  localparam int MAX_OPT_WORDS = 6;  // MSS + window scale + SACK-permitted + timestamp
  localparam int MAX_HDR_LEN   = MIN_HDR_LEN + 4 * MAX_OPT_WORDS;
  localparam int BASE_OFFSET   = 5;  // Data offset with no options
  localparam int CKS_POS       = 16; // First checksum byte in the header

  // Option kinds
  localparam logic [7:0] OPT_NOP       = 8'd1;
  localparam logic [7:0] OPT_MSS       = 8'd2;
  localparam logic [7:0] OPT_WIN       = 8'd3;
  localparam logic [7:0] OPT_SACK_PERM = 8'd4;
  localparam logic [7:0] OPT_TS        = 8'd8;

  // Option length fields
  localparam logic [7:0] OPT_MSS_LEN       = 8'd4;
  localparam logic [7:0] OPT_WIN_LEN       = 8'd3;
  localparam logic [7:0] OPT_SACK_PERM_LEN = 8'd2;
  localparam logic [7:0] OPT_TS_LEN        = 8'd10;
  localparam int         TS_WORDS          = 3; // Kind word plus send and echo values

  // Presence bit per option slot
  localparam int OPT_SLOTS      = 4;
  localparam int SLOT_MSS       = 0;
  localparam int SLOT_WIN       = 1;
  localparam int SLOT_SACK_PERM = 2;
  localparam int SLOT_TS        = 3;

  localparam logic [7:0] PROTO_TCP = 8'd6; // IPv4 protocol number for the pseudo header

endpackage : tcp_hdr_pkg

`default_nettype wire

// File: source/tcp_strm_pkg.sv
`default_nettype none

package tcp_strm_pkg;

  localparam int LEN_W = 16; // Byte lengths
  localparam int CKS_W = 32; // Checksum accumulator before folding

  // Halfword pad to widen a 16-bit term to the accumulator
  localparam int HW_PAD_W = CKS_W - 16;

  // Source and destination address, zero, protocol, TCP length
  localparam int PSEUDO_HALFWORDS = 6;

endpackage : tcp_strm_pkg

`default_nettype wire

// File: source/tcp_opt_pack.sv
`default_nettype none

module tcp_opt_pack (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic                                       meta_val,
  output logic                                       meta_rdy,
  input  logic [31:0]                                src_ip,
  input  logic [31:0]                                dst_ip,
  input  logic [15:0]                                src_port,
  input  logic [15:0]                                dst_port,
  input  logic [31:0]                                seq_num,
  input  logic [31:0]                                ack_num,
  input  logic [8:0]                                 flags,
  input  logic [15:0]                                wnd_size,
  input  logic [15:0]                                urg_ptr,
  input  logic [tcp_hdr_pkg::OPT_SLOTS-1:0]          opt_pres,
  input  logic [15:0]                                mss,
  input  logic [7:0]                                 wnd_scale,
  input  logic [31:0]                                ts_snd,
  input  logic [31:0]                                ts_rec,
  input  logic [tcp_strm_pkg::LEN_W-1:0]             pld_len,
  input  logic [tcp_strm_pkg::CKS_W-1:0]             pld_cks,
  output logic                                       s1_val,
  input  logic                                       s1_rdy,
  output logic [0:tcp_hdr_pkg::MAX_HDR_LEN-1][7:0]   hdr_bytes,
  output logic [tcp_strm_pkg::LEN_W-1:0]             hdr_len,
  output logic [tcp_strm_pkg::LEN_W-1:0]             s1_pld_len,
  output logic [tcp_strm_pkg::CKS_W-1:0]             s1_pld_cks,
  output logic [31:0]                                s1_src_ip,
  output logic [31:0]                                s1_dst_ip
);

  typedef enum logic [1:0] {idle_s, shift_s, hold_s} state_t;

  state_t                                          state;
  logic [0:tcp_hdr_pkg::MIN_HDR_LEN-1][7:0]        base_hdr;
  logic [0:tcp_hdr_pkg::MAX_OPT_WORDS-1][31:0]     opt_blk;   // Packed options, first at word 0
  logic [0:tcp_hdr_pkg::MAX_OPT_WORDS-1][31:0]     opt_proto; // Every option, last one first
  logic [0:tcp_hdr_pkg::MAX_OPT_WORDS-1]           opt_mask;
  logic [2:0]                                      shift_cnt;
  logic [2:0]                                      opt_words;
  logic [3:0]                                      data_off;

  assign opt_words = 3'(opt_pres[tcp_hdr_pkg::SLOT_MSS]) + 3'(opt_pres[tcp_hdr_pkg::SLOT_WIN]) +
                     3'(opt_pres[tcp_hdr_pkg::SLOT_SACK_PERM]) +
                     (opt_pres[tcp_hdr_pkg::SLOT_TS] ? 3'(tcp_hdr_pkg::TS_WORDS) : 3'd0);
  assign data_off  = 4'(tcp_hdr_pkg::BASE_OFFSET) + {1'b0, opt_words};

  assign meta_rdy  = (state == idle_s);
  assign hdr_bytes = {base_hdr, opt_blk};

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= idle_s;
      s1_val    <= 1'b0;
      shift_cnt <= '0;
    end else begin
      case (state)
        idle_s : begin
          if (meta_val) begin
            base_hdr   <= {src_port, dst_port, seq_num, ack_num, data_off, 3'b000, flags,
                           wnd_size, 16'h0000, urg_ptr}; // Checksum left zero for stage 2
            hdr_len    <= {{(tcp_strm_pkg::LEN_W-6){1'b0}}, data_off, 2'b00};
            s1_pld_len <= pld_len;
            s1_pld_cks <= pld_cks;
            s1_src_ip  <= src_ip;
            s1_dst_ip  <= dst_ip;
            opt_blk    <= '0;
            opt_proto  <= {ts_rec, ts_snd,
                           {tcp_hdr_pkg::OPT_NOP, tcp_hdr_pkg::OPT_NOP,
                            tcp_hdr_pkg::OPT_TS, tcp_hdr_pkg::OPT_TS_LEN},
                           {tcp_hdr_pkg::OPT_NOP, tcp_hdr_pkg::OPT_NOP,
                            tcp_hdr_pkg::OPT_SACK_PERM, tcp_hdr_pkg::OPT_SACK_PERM_LEN},
                           {tcp_hdr_pkg::OPT_NOP, tcp_hdr_pkg::OPT_WIN,
                            tcp_hdr_pkg::OPT_WIN_LEN, wnd_scale},
                           {tcp_hdr_pkg::OPT_MSS, tcp_hdr_pkg::OPT_MSS_LEN, mss}};
            opt_mask   <= {{tcp_hdr_pkg::TS_WORDS{opt_pres[tcp_hdr_pkg::SLOT_TS]}},
                           opt_pres[tcp_hdr_pkg::SLOT_SACK_PERM],
                           opt_pres[tcp_hdr_pkg::SLOT_WIN],
                           opt_pres[tcp_hdr_pkg::SLOT_MSS]};
            shift_cnt  <= '0;
            state      <= shift_s;
          end
        end
        shift_s : begin
          // Fixed six steps so the latency never depends on the options
          opt_proto <= opt_proto << 32;
          opt_mask  <= opt_mask << 1;
          if (opt_mask[0]) opt_blk <= {opt_proto[0], opt_blk[0:tcp_hdr_pkg::MAX_OPT_WORDS-2]};
          shift_cnt <= shift_cnt + 3'd1;
          if (shift_cnt == 3'(tcp_hdr_pkg::MAX_OPT_WORDS - 1)) begin
            s1_val <= 1'b1;
            state  <= hold_s;
          end
        end
        default : begin
          if (s1_rdy) begin // Stage 2 takes the segment
            s1_val <= 1'b0;
            state  <= idle_s;
          end
        end
      endcase
    end
  end

  a_hdr_len_range : assert property (@(posedge clk) disable iff (rst)
    s1_val |-> (hdr_len >= tcp_hdr_pkg::MIN_HDR_LEN) && (hdr_len <= tcp_hdr_pkg::MAX_HDR_LEN) &&
               (hdr_len[1:0] == 2'b00));

endmodule : tcp_opt_pack

`default_nettype wire

// File: source/tcp_cks_calc.sv
`default_nettype none

module tcp_cks_calc (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic                                       s1_val,
  output logic                                       s1_rdy,
  input  logic [0:tcp_hdr_pkg::MAX_HDR_LEN-1][7:0]   hdr_bytes,
  input  logic [tcp_strm_pkg::LEN_W-1:0]             hdr_len,
  input  logic [tcp_strm_pkg::LEN_W-1:0]             s1_pld_len,
  input  logic [tcp_strm_pkg::CKS_W-1:0]             s1_pld_cks,
  input  logic [31:0]                                s1_src_ip,
  input  logic [31:0]                                s1_dst_ip,
  output logic                                       s2_val,
  input  logic                                       s2_rdy,
  output logic [0:tcp_hdr_pkg::MAX_HDR_LEN-1][7:0]   s2_hdr_bytes,
  output logic [tcp_strm_pkg::LEN_W-1:0]             s2_hdr_len,
  output logic [tcp_strm_pkg::LEN_W-1:0]             s2_pld_len
);

  typedef enum logic [1:0] {idle_s, calc_s, fold_s, hold_s} state_t;

  state_t                                              state;
  logic [0:tcp_hdr_pkg::MAX_HDR_LEN-1][7:0]            calc_sr;   // Header copy shifted for summing
  logic [0:tcp_strm_pkg::PSEUDO_HALFWORDS-1][15:0]     pseudo_sr;
  logic [tcp_strm_pkg::CKS_W-1:0]                      hdr_sum;
  logic [tcp_strm_pkg::CKS_W-1:0]                      pseudo_sum;
  logic [tcp_strm_pkg::CKS_W-1:0]                      total;
  logic [16:0]                                         fold1;
  logic [15:0]                                         fold2;
  logic [tcp_strm_pkg::LEN_W-1:0]                      half_cnt;

  assign s1_rdy = (state == idle_s);

  // Two folds are enough for any sum of a 44-byte header and a short payload
  assign total = hdr_sum + pseudo_sum;
  assign fold1 = {1'b0, total[tcp_strm_pkg::CKS_W-1:16]} + {1'b0, total[15:0]};
  assign fold2 = fold1[15:0] + {15'd0, fold1[16]};

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= idle_s;
      s2_val   <= 1'b0;
      half_cnt <= '0;
    end else begin
      case (state)
        idle_s : begin
          if (s1_val) begin
            calc_sr      <= hdr_bytes;
            s2_hdr_bytes <= hdr_bytes;
            s2_hdr_len   <= hdr_len;
            s2_pld_len   <= s1_pld_len;
            pseudo_sr    <= {s1_src_ip, s1_dst_ip, 8'h00, tcp_hdr_pkg::PROTO_TCP,
                             hdr_len + s1_pld_len};
            hdr_sum      <= s1_pld_cks; // Payload sum is the starting value
            pseudo_sum   <= '0;
            half_cnt     <= '0;
            state        <= calc_s;
          end
        end
        calc_s : begin
          calc_sr  <= calc_sr << 16;
          hdr_sum  <= hdr_sum + {{tcp_strm_pkg::HW_PAD_W{1'b0}}, calc_sr[0:1]};
          if (half_cnt < tcp_strm_pkg::PSEUDO_HALFWORDS) begin // Pseudo header runs alongside
            pseudo_sr  <= pseudo_sr << 16;
            pseudo_sum <= pseudo_sum + {{tcp_strm_pkg::HW_PAD_W{1'b0}}, pseudo_sr[0]};
          end
          half_cnt <= half_cnt + 1'b1;
          if (half_cnt == (s2_hdr_len >> 1) - 1'b1) state <= fold_s;
        end
        fold_s : begin
          s2_hdr_bytes[tcp_hdr_pkg::CKS_POS +: 2] <= ~fold2;
          s2_val                                  <= 1'b1;
          state                                   <= hold_s;
        end
        default : begin
          if (s2_rdy) begin
            s2_val <= 1'b0;
            state  <= idle_s;
          end
        end
      endcase
    end
  end

  // Stage 3 may stall for a whole segment, the handoff must not move meanwhile
  a_s2_hold : assert property (@(posedge clk) disable iff (rst)
    s2_val && !s2_rdy |=> s2_val && $stable(s2_hdr_bytes) && $stable(s2_hdr_len) &&
                          $stable(s2_pld_len));

endmodule : tcp_cks_calc

`default_nettype wire

// File: source/tcp_seg_tx.sv
`default_nettype none

module tcp_seg_tx (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic                                       s2_val,
  output logic                                       s2_rdy,
  input  logic [0:tcp_hdr_pkg::MAX_HDR_LEN-1][7:0]   s2_hdr_bytes,
  input  logic [tcp_strm_pkg::LEN_W-1:0]             s2_hdr_len,
  input  logic [tcp_strm_pkg::LEN_W-1:0]             s2_pld_len,
  input  logic                                       pld_val,
  input  logic [7:0]                                 pld_dat,
  output logic                                       pld_rdy,
  output logic                                       out_val,
  output logic [7:0]                                 out_dat,
  output logic                                       out_sof,
  output logic                                       out_eof,
  input  logic                                       out_rdy,
  output logic                                       done
);

  typedef enum logic [1:0] {idle_s, hdr_s, pld_s, tail_s} state_t;

  state_t                                    state;
  logic [0:tcp_hdr_pkg::MAX_HDR_LEN-1][7:0]  hdr_sr;
  logic [tcp_strm_pkg::LEN_W-1:0]            hdr_len_q;
  logic [tcp_strm_pkg::LEN_W-1:0]            pld_len_q;
  logic [tcp_strm_pkg::LEN_W-1:0]            hdr_cnt;   // Header bytes loaded into out_dat
  logic [tcp_strm_pkg::LEN_W-1:0]            pld_cnt;

  assign s2_rdy  = (state == idle_s);
  assign pld_rdy = (state == pld_s) && (!out_val || out_rdy); // Output register free this cycle

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= idle_s;
      out_val <= 1'b0;
      out_sof <= 1'b0;
      out_eof <= 1'b0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        idle_s : begin
          if (s2_val && s2_rdy) begin
            out_dat   <= s2_hdr_bytes[0]; // First byte goes straight out
            out_val   <= 1'b1;
            out_sof   <= 1'b1;
            out_eof   <= 1'b0;
            hdr_sr    <= s2_hdr_bytes << 8;
            hdr_len_q <= s2_hdr_len;
            pld_len_q <= s2_pld_len;
            hdr_cnt   <= 1;
            pld_cnt   <= '0;
            state     <= hdr_s;
          end
        end
        hdr_s : begin
          if (out_rdy) begin
            out_dat <= hdr_sr[0];
            out_sof <= 1'b0;
            hdr_sr  <= hdr_sr << 8;
            hdr_cnt <= hdr_cnt + 1'b1;
            if (hdr_cnt == hdr_len_q - 1'b1) begin
              // Payload may follow the last header byte with no gap
              out_eof <= (pld_len_q == 0);
              state   <= (pld_len_q == 0) ? tail_s : pld_s;
            end
          end
        end
        pld_s : begin
          if (pld_val && pld_rdy) begin
            out_dat <= pld_dat;
            out_val <= 1'b1;
            out_eof <= (pld_cnt == pld_len_q - 1'b1);
            pld_cnt <= pld_cnt + 1'b1;
            if (pld_cnt == pld_len_q - 1'b1) state <= tail_s;
          end else if (out_rdy) begin
            out_val <= 1'b0; // Source gap
          end
        end
        default : begin
          if (out_rdy) begin // Eof byte leaves
            out_val <= 1'b0;
            out_eof <= 1'b0;
            done    <= 1'b1;
            state   <= idle_s;
          end
        end
      endcase
    end
  end

  a_sof_eof_apart : assert property (@(posedge clk) disable iff (rst)
    !(out_sof && out_eof));

  // Payload is only pulled once the whole header has been loaded
  a_pld_after_hdr : assert property (@(posedge clk) disable iff (rst)
    pld_rdy |-> (hdr_cnt == hdr_len_q));

endmodule : tcp_seg_tx

`default_nettype wire

// File: source/tcp_tx.sv
`default_nettype none

module tcp_tx (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               meta_val,
  output logic                               meta_rdy,
  input  logic [31:0]                        src_ip,
  input  logic [31:0]                        dst_ip,
  input  logic [15:0]                        src_port,
  input  logic [15:0]                        dst_port,
  input  logic [31:0]                        seq_num,
  input  logic [31:0]                        ack_num,
  input  logic [8:0]                         flags,
  input  logic [15:0]                        wnd_size,
  input  logic [15:0]                        urg_ptr,
  input  logic [tcp_hdr_pkg::OPT_SLOTS-1:0]  opt_pres,
  input  logic [15:0]                        mss,
  input  logic [7:0]                         wnd_scale,
  input  logic [31:0]                        ts_snd,
  input  logic [31:0]                        ts_rec,
  input  logic [tcp_strm_pkg::LEN_W-1:0]     pld_len,
  input  logic [tcp_strm_pkg::CKS_W-1:0]     pld_cks,
  input  logic                               pld_val,
  input  logic [7:0]                         pld_dat,
  output logic                               pld_rdy,
  output logic                               out_val,
  output logic [7:0]                         out_dat,
  output logic                               out_sof,
  output logic                               out_eof,
  input  logic                               out_rdy,
  output logic                               done
);

  // Stage 1 to stage 2
  logic                                      s1_val;
  logic                                      s1_rdy;
  logic [0:tcp_hdr_pkg::MAX_HDR_LEN-1][7:0]  s1_hdr_bytes;
  logic [tcp_strm_pkg::LEN_W-1:0]            s1_hdr_len;
  logic [tcp_strm_pkg::LEN_W-1:0]            s1_pld_len;
  logic [tcp_strm_pkg::CKS_W-1:0]            s1_pld_cks;
  logic [31:0]                               s1_src_ip;
  logic [31:0]                               s1_dst_ip;

  // Stage 2 to stage 3
  logic                                      s2_val;
  logic                                      s2_rdy;
  logic [0:tcp_hdr_pkg::MAX_HDR_LEN-1][7:0]  s2_hdr_bytes;
  logic [tcp_strm_pkg::LEN_W-1:0]            s2_hdr_len;
  logic [tcp_strm_pkg::LEN_W-1:0]            s2_pld_len;

  tcp_opt_pack u_opt_pack (
    .clk, .rst, .meta_val, .meta_rdy, .src_ip, .dst_ip, .src_port, .dst_port,
    .seq_num, .ack_num, .flags, .wnd_size, .urg_ptr, .opt_pres, .mss, .wnd_scale,
    .ts_snd, .ts_rec, .pld_len, .pld_cks, .s1_val, .s1_rdy,
    .hdr_bytes (s1_hdr_bytes),
    .hdr_len   (s1_hdr_len),
    .s1_pld_len, .s1_pld_cks, .s1_src_ip, .s1_dst_ip
  );

  tcp_cks_calc u_cks_calc (
    .clk, .rst, .s1_val, .s1_rdy,
    .hdr_bytes (s1_hdr_bytes),
    .hdr_len   (s1_hdr_len),
    .s1_pld_len, .s1_pld_cks, .s1_src_ip, .s1_dst_ip,
    .s2_val, .s2_rdy, .s2_hdr_bytes, .s2_hdr_len, .s2_pld_len
  );

  tcp_seg_tx u_seg_tx (
    .clk, .rst, .s2_val, .s2_rdy, .s2_hdr_bytes, .s2_hdr_len, .s2_pld_len,
    .pld_val, .pld_dat, .pld_rdy,
    .out_val, .out_dat, .out_sof, .out_eof, .out_rdy, .done
  );

endmodule : tcp_tx

`default_nettype wire

// File: verif/tcp_tx_model.svh
`ifndef TCP_TX_MODEL_SVH
`define TCP_TX_MODEL_SVH

typedef logic [7:0] byte_q_t[$];

// One segment's metadata, in the order of the DUT ports
typedef struct packed {
  logic [31:0] src_ip;
  logic [31:0] dst_ip;
  logic [15:0] src_port;
  logic [15:0] dst_port;
  logic [31:0] seq_num;
  logic [31:0] ack_num;
  logic [8:0]  flags;
  logic [15:0] wnd_size;
  logic [15:0] urg_ptr;
  logic [3:0]  opt_pres;
  logic [15:0] mss;
  logic [7:0]  wnd_scale;
  logic [31:0] ts_snd;
  logic [31:0] ts_rec;
  logic [15:0] pld_len;
  logic [31:0] pld_cks;
} meta_t;

// Unfolded sum of payload halfwords, odd last byte padded low
function automatic logic [31:0] payload_sum(byte_q_t pld);
  logic [31:0] sum;
  sum = '0;
  for (int i = 0; i < pld.size(); i += 2) begin
    if (i + 1 < pld.size()) sum += {16'h0000, pld[i], pld[i+1]};
    else sum += {16'h0000, pld[i], 8'h00};
  end
  return sum;
endfunction

function automatic logic [15:0] fold_sum(logic [31:0] sum);
  logic [31:0] s;
  s = sum;
  while (s[31:16] != 16'h0000) s = {16'h0000, s[15:0]} + {16'h0000, s[31:16]};
  return s[15:0];
endfunction

// Full segment as it should leave the DUT, header then payload
function automatic byte_q_t build_segment(meta_t m, byte_q_t pld);
  logic [31:0] opts[$];
  logic [31:0] hdr[$];
  logic [31:0] sum;
  logic [15:0] tcp_len;
  logic [3:0]  data_off;
  byte_q_t     seg;
  if (m.opt_pres[tcp_hdr_pkg::SLOT_MSS])
    opts.push_back({tcp_hdr_pkg::OPT_MSS, tcp_hdr_pkg::OPT_MSS_LEN, m.mss});
  if (m.opt_pres[tcp_hdr_pkg::SLOT_WIN])
    opts.push_back({tcp_hdr_pkg::OPT_NOP, tcp_hdr_pkg::OPT_WIN, tcp_hdr_pkg::OPT_WIN_LEN,
                    m.wnd_scale});
  if (m.opt_pres[tcp_hdr_pkg::SLOT_SACK_PERM])
    opts.push_back({tcp_hdr_pkg::OPT_NOP, tcp_hdr_pkg::OPT_NOP, tcp_hdr_pkg::OPT_SACK_PERM,
                    tcp_hdr_pkg::OPT_SACK_PERM_LEN});
  if (m.opt_pres[tcp_hdr_pkg::SLOT_TS]) begin
    opts.push_back({tcp_hdr_pkg::OPT_NOP, tcp_hdr_pkg::OPT_NOP, tcp_hdr_pkg::OPT_TS,
                    tcp_hdr_pkg::OPT_TS_LEN});
    opts.push_back(m.ts_snd);
    opts.push_back(m.ts_rec);
  end
  data_off = 4'(tcp_hdr_pkg::BASE_OFFSET + opts.size());
  hdr.push_back({m.src_port, m.dst_port});
  hdr.push_back(m.seq_num);
  hdr.push_back(m.ack_num);
  hdr.push_back({data_off, 3'b000, m.flags, m.wnd_size});
  hdr.push_back({16'h0000, m.urg_ptr}); // Checksum zero while summing
  foreach (opts[i]) hdr.push_back(opts[i]);
  tcp_len = 16'(4 * hdr.size()) + m.pld_len;
  sum = {16'h0000, m.src_ip[31:16]} + {16'h0000, m.src_ip[15:0]} +
        {16'h0000, m.dst_ip[31:16]} + {16'h0000, m.dst_ip[15:0]} +
        {24'h000000, tcp_hdr_pkg::PROTO_TCP} + {16'h0000, tcp_len};
  foreach (hdr[i]) sum += {16'h0000, hdr[i][31:16]} + {16'h0000, hdr[i][15:0]};
  sum += payload_sum(pld);
  hdr[4] = {~fold_sum(sum), m.urg_ptr};
  foreach (hdr[i]) begin
    for (int b = 3; b >= 0; b--) seg.push_back(hdr[i][8*b +: 8]);
  end
  foreach (pld[i]) seg.push_back(pld[i]);
  return seg;
endfunction

`endif

// File: verif/tcp_tx_tb.sv
`default_nettype none

module tcp_tx_tb;
  timeunit 1ns;
  timeprecision 1ps;

  `include "tcp_tx_model.svh"

  logic       clk;
  logic       rst;
  logic       meta_val;
  logic       meta_rdy;
  meta_t      meta_in;
  logic       pld_val;
  logic [7:0] pld_dat;
  logic       pld_rdy;
  logic       out_val;
  logic [7:0] out_dat;
  logic       out_sof;
  logic       out_eof;
  logic       out_rdy;
  logic       done;

  meta_t      meta_q[$];
  logic [7:0] pld_q[$];
  logic [9:0] exp_q[$];  // {sof, eof, byte}
  bit         throttle;  // Random gaps on pld_val and out_rdy
  bit         timed_out;
  bit         eof_moved; // Eof byte left on the last edge
  int         err_cnt;
  int         done_cnt;
  int         pld_rdy_cnt;
  int         tests_run;
  int         tests_failed;

  tcp_tx DUT (
    .clk, .rst, .meta_val, .meta_rdy,
    .src_ip   (meta_in.src_ip),   .dst_ip    (meta_in.dst_ip),
    .src_port (meta_in.src_port), .dst_port  (meta_in.dst_port),
    .seq_num  (meta_in.seq_num),  .ack_num   (meta_in.ack_num),
    .flags    (meta_in.flags),    .wnd_size  (meta_in.wnd_size),
    .urg_ptr  (meta_in.urg_ptr),  .opt_pres  (meta_in.opt_pres),
    .mss      (meta_in.mss),      .wnd_scale (meta_in.wnd_scale),
    .ts_snd   (meta_in.ts_snd),   .ts_rec    (meta_in.ts_rec),
    .pld_len  (meta_in.pld_len),  .pld_cks   (meta_in.pld_cks),
    .pld_val, .pld_dat, .pld_rdy, .out_val, .out_dat, .out_sof, .out_eof, .out_rdy, .done
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Inputs move 10 ns after the rising edge
  always @(posedge clk) begin
    #10;
    meta_val = (meta_q.size() > 0);
    if (meta_q.size() > 0) meta_in = meta_q[0];
    if (pld_q.size() > 0 && (!throttle || $urandom_range(3, 0) != 0)) begin
      pld_val = 1'b1;
      pld_dat = pld_q[0];
    end else begin
      pld_val = 1'b0;
    end
    out_rdy = !throttle || ($urandom_range(2, 0) != 0);
  end

  // Mid-cycle view of the handshakes that complete on the next edge
  always @(negedge clk) begin
    if (!rst) begin
      if (meta_val && meta_rdy) void'(meta_q.pop_front());
      if (pld_val && pld_rdy) void'(pld_q.pop_front());
      if (pld_rdy) pld_rdy_cnt++;
      if (done) done_cnt++;
      // Done follows the eof byte by exactly one cycle
      assert (done == eof_moved) else report_mismatch("done", done, eof_moved);
      eof_moved = out_val && out_rdy && out_eof;
      if (out_val && out_rdy) check_out_byte();
    end
  end

  task automatic report_mismatch(input string name, input int got, input int exp);
    $display("ERROR %0d ns %s: got %0h expected %0h", $time, name, got, exp);
    err_cnt++;
  endtask

  task automatic check_out_byte();
    logic [9:0] exp;
    assert (exp_q.size() > 0) else begin
      $display("Output byte %02h at %0d ns arrived with no segment expected", out_dat, $time);
      err_cnt++;
    end
    if (exp_q.size() > 0) begin
      exp = exp_q.pop_front();
      assert (out_dat == exp[7:0]) else report_mismatch("out_dat", out_dat, exp[7:0]);
      assert (out_sof == exp[9]) else report_mismatch("out_sof", out_sof, exp[9]);
      assert (out_eof == exp[8]) else report_mismatch("out_eof", out_eof, exp[8]);
    end
  endtask

  task automatic finish_test(input int num, input string name, input int errs_before);
    tests_run++;
    if (err_cnt == errs_before) begin
      $display("Test %0d %s: passed", num, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: failed with %0d errors", num, name, err_cnt - errs_before);
    end
  endtask

  task automatic queue_segment(input logic [3:0] opts, input int max_len);
    meta_t   m;
    byte_q_t pld;
    byte_q_t seg;
    int      len;
    len = $urandom_range(max_len, 0);
    for (int i = 0; i < len; i++) pld.push_back(8'($urandom));
    m.src_ip    = $urandom;
    m.dst_ip    = $urandom;
    m.src_port  = 16'($urandom);
    m.dst_port  = 16'($urandom);
    m.seq_num   = $urandom;
    m.ack_num   = $urandom;
    m.flags     = 9'($urandom);
    m.wnd_size  = 16'($urandom);
    m.urg_ptr   = 16'($urandom);
    m.opt_pres  = opts;
    m.mss       = 16'($urandom);
    m.wnd_scale = 8'($urandom);
    m.ts_snd    = $urandom;
    m.ts_rec    = $urandom;
    m.pld_len   = 16'(len);
    m.pld_cks   = payload_sum(pld);
    seg = build_segment(m, pld);
    meta_q.push_back(m);
    foreach (pld[i]) pld_q.push_back(pld[i]);
    foreach (seg[i]) exp_q.push_back({i == 0, i == seg.size() - 1, seg[i]});
  endtask

  // opt_kind 0 is no options, 1 walks every presence pattern, 2 is random
  task automatic run_batch(input int num, input string name, input int n_seg,
                           input int opt_kind, input int max_len, input bit thr);
    int         errs;
    int         done_base;
    int         rdy_base;
    int         cyc;
    logic [3:0] opts;
    errs = err_cnt;
    @(posedge clk);
    done_base = done_cnt;
    rdy_base  = pld_rdy_cnt;
    throttle  = thr;
    for (int i = 0; i < n_seg; i++) begin
      opts = (opt_kind == 0) ? 4'h0 : (opt_kind == 1) ? 4'(i) : 4'($urandom);
      queue_segment(opts, max_len);
    end
    cyc = 0;
    while (done_cnt - done_base < n_seg && cyc < n_seg * 600) begin
      @(posedge clk);
      cyc++;
    end
    assert (done_cnt - done_base >= n_seg) else begin
      $display("Test %0d timed out after %0d cycles with %0d of %0d segments done",
               num, cyc, done_cnt - done_base, n_seg);
      err_cnt++;
      timed_out = 1'b1;
    end
    repeat (4) @(posedge clk); // Idle gap shows any extra done pulse
    assert (done_cnt - done_base == n_seg) else
      report_mismatch("done count", done_cnt - done_base, n_seg);
    assert (exp_q.size() == 0) else begin
      $display("%0d expected output bytes never arrived", exp_q.size());
      err_cnt++;
    end
    if (max_len == 0) begin
      assert (pld_rdy_cnt == rdy_base) else begin
        $display("pld_rdy was high for %0d cycles with no payload", pld_rdy_cnt - rdy_base);
        err_cnt++;
      end
    end
    throttle = 1'b0;
    finish_test(num, name, errs);
  endtask

  task automatic reset_test();
    int errs;
    errs = err_cnt;
    @(posedge clk);
    #20;
    assert (out_val == 1'b0) else report_mismatch("out_val", out_val, 0);
    assert (out_sof == 1'b0) else report_mismatch("out_sof", out_sof, 0);
    assert (out_eof == 1'b0) else report_mismatch("out_eof", out_eof, 0);
    assert (pld_rdy == 1'b0) else report_mismatch("pld_rdy", pld_rdy, 0);
    assert (done == 1'b0) else report_mismatch("done", done, 0);
    assert (meta_rdy == 1'b1) else report_mismatch("meta_rdy", meta_rdy, 1);
    finish_test(1, "reset state", errs);
  endtask

  initial begin
    rst      = 1'b1;
    meta_val = 1'b0;
    meta_in  = '0;
    pld_val  = 1'b0;
    pld_dat  = 8'h00;
    out_rdy  = 1'b0;
    void'($urandom(97933));
    repeat (10) @(posedge clk);
    #10 rst = 1'b0;
    reset_test();
    if (!timed_out) run_batch(2, "no options", 12, 0, 40, 1'b0);
    if (!timed_out) run_batch(3, "option patterns", 32, 1, 40, 1'b0);
    if (!timed_out) run_batch(4, "zero payload", 8, 2, 0, 1'b0);
    if (!timed_out) run_batch(5, "back-pressure and gaps", 40, 2, 40, 1'b1);
    if (!timed_out) run_batch(6, "back-to-back", 50, 2, 40, 1'b0);
    $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, err_cnt);
    if (tests_failed == 0 && err_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule : tcp_tx_tb

`default_nettype wire

// File: verilog.f
+incdir+verif
source/tcp_hdr_pkg.sv
source/tcp_strm_pkg.sv
source/tcp_opt_pack.sv
source/tcp_cks_calc.sv
source/tcp_seg_tx.sv
source/tcp_tx.sv
verif/tcp_tx_tb.sv

// File: run_sim.sh
#!/bin/bash
# Build the testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --timing -Wno-fatal --top-module tcp_tx_tb -f verilog.f \
  -Mdir obj_dir \
  && ./obj_dir/Vtcp_tx_tb | tee sim.log \
  || { echo "Build or simulation did not complete"; exit 1; }
grep -qx '\*\* PASS \*\*' sim.log && exit 0 || exit 1
